//--- verilog/unpack_pkg.sv
/* Shared definitions for the CHDR 12-bit to 16-bit complex sample unpacker.
   Holds the phase encoding, header field positions and byte constants. */

package unpack_pkg;

   // ########################################################################
   // Sequencer phases
   // ########################################################################

   // One phase per output line. LINE0 to LINE3 repeat for every three input lines.
   typedef enum logic [2:0] {
      ST_HEADER = 3'd0,
      ST_TIME   = 3'd1,
      ST_LINE0  = 3'd2,
      ST_LINE1  = 3'd3,
      ST_LINE2  = 3'd4,
      ST_LINE3  = 3'd5
   } unpack_state_t;

   // ########################################################################
   // Settings bus and header layout
   // ########################################################################

   localparam logic [7:0] SID_REG_ADDR = 8'h10;  // Destination override register.
   localparam int         SID_W        = 16;     // Width of a stream ID half.
   localparam int         SID_EN_BIT   = 16;     // Enable bit in the register data.

   localparam int HDR_HAS_TIME_BIT = 61;         // Set when a time word follows.
   localparam int LEN_MSB          = 47;
   localparam int LEN_LSB          = 32;         // Length field is in bytes.

   localparam logic [15:0] HDR_BYTES  = 16'd8;
   localparam logic [15:0] TIME_BYTES = 16'd8;

   // Fraction bits of the fixed point reciprocal of three used by the length
   // calculation. Eighteen bits keep the 4/3 product exact for any 16-bit length.
   localparam int RECIP_BITS = 18;

endpackage

//--- verilog/sid_setting_reg.sv
/* Settings-bus register for the destination stream ID override.
   Holds the new destination and its enable. */

`timescale 1ns/100ps

module sid_setting_reg
   import unpack_pkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  logic             i_set_stb,
   input  logic [7:0]       i_set_addr,
   input  logic [31:0]      i_set_data,
   output logic             o_sid_en,
   output logic [SID_W-1:0] o_new_dest
);

   logic [SID_W:0] sid_reg;  // Enable on top, destination below.

   always_ff @(posedge clk) begin
      if (reset) begin
         sid_reg <= '0;
      end else if (i_set_stb && (i_set_addr == SID_REG_ADDR)) begin
         sid_reg <= i_set_data[SID_EN_BIT:0];
      end
   end

   assign o_sid_en   = sid_reg[SID_EN_BIT];
   assign o_new_dest = sid_reg[SID_W-1:0];

endmodule

//--- verilog/pkt_length_calc.sv
/* Output length of a packet once its 12-bit samples grow to 16 bits,
   and whether the output needs a line beyond the input's last beat. */

`timescale 1ns/100ps

module pkt_length_calc
   import unpack_pkg::*;
(
   input  logic [63:0] i_hdr,
   output logic [15:0] o_out_len,
   output logic        o_has_exline
);

   logic        has_time;
   logic [15:0] hdr_total;   // Header plus optional time word, in bytes.
   logic [15:0] in_bytes;    // Input sample bytes.
   logic [35:0] in_ext;
   logic [35:0] third_acc;   // in_bytes times (2^18 - 1) / 3.
   logic [35:0] scaled;
   logic [15:0] out_bytes;   // Output sample bytes.

   assign has_time  = i_hdr[HDR_HAS_TIME_BIT];
   assign hdr_total = HDR_BYTES + (has_time ? TIME_BYTES : 16'd0);
   assign in_bytes  = i_hdr[LEN_MSB:LEN_LSB] - hdr_total;
   assign in_ext    = {20'd0, in_bytes};

   // Constant multiply by 0.010101...01 binary, nine ones.
   assign third_acc = in_ext
                    + (in_ext << 2)
                    + (in_ext << 4)
                    + (in_ext << 6)
                    + (in_ext << 8)
                    + (in_ext << 10)
                    + (in_ext << 12)
                    + (in_ext << 14)
                    + (in_ext << 16);

   // Times four, then round so the truncated reciprocal lands on the exact result.
   assign scaled    = (third_acc << 2) + (36'd1 << (RECIP_BITS - 1));
   assign out_bytes = scaled[RECIP_BITS +: 16];

   assign o_out_len = hdr_total + out_bytes;

   // Bits 4:2 give the sample count modulo eight. Counts ending in 0, 5 or 7
   // leave output data still to send after the last input line.
   always_comb begin
      case (out_bytes[4:2])
         3'd0, 3'd5, 3'd7: o_has_exline = 1'b1;
         default:          o_has_exline = 1'b0;
      endcase
   end

endmodule

//--- verilog/unpack_ctrl_fsm.sv
/* Sequencer for the unpacker. Walks header, time and the four line phases,
   and drives the stream handshakes and the hold register enable. */

`timescale 1ns/100ps

module unpack_ctrl_fsm
   import unpack_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          i_tlast,
   input  logic          i_tvalid,
   input  logic          i_tready,      // Downstream ready.
   input  logic          i_has_time,
   input  logic          i_has_exline,
   output unpack_state_t o_state,
   output logic          o_in_tready,
   output logic          o_out_tvalid,
   output logic          o_out_tlast,
   output logic          o_hold_en
);

   unpack_state_t state;
   unpack_state_t next_line;   // Phase after the current line phase.
   logic          has_exline;  // Packet ends one line after its last input beat.
   logic          in_exline;   // Sending that extra line now.
   logic          out_xfer;

   always_comb begin
      case (state)
         ST_LINE0: next_line = ST_LINE1;
         ST_LINE1: next_line = ST_LINE2;
         ST_LINE2: next_line = ST_LINE3;
         default:  next_line = ST_LINE0;
      endcase
   end

   // LINE3 and the extra line are built from the hold register alone.
   assign o_out_tvalid = in_exline || (state == ST_LINE3) || i_tvalid;
   assign o_in_tready  = (state != ST_LINE3) && !in_exline && i_tready;
   assign o_hold_en    = i_tvalid && o_in_tready;
   assign out_xfer     = o_out_tvalid && i_tready;

   always_comb begin
      if (in_exline) begin
         o_out_tlast = 1'b1;
      end else if (state == ST_TIME) begin
         o_out_tlast = i_tlast;  // Packet without samples.
      end else begin
         o_out_tlast = i_tlast && !has_exline && (state != ST_LINE3);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ST_HEADER;
         has_exline <= 1'b0;
         in_exline  <= 1'b0;
      end else if (out_xfer) begin
         case (state)
            ST_HEADER: begin
               has_exline <= i_has_exline;
               state      <= i_has_time ? ST_TIME : ST_LINE0;
            end

            ST_TIME: begin
               state <= i_tlast ? ST_HEADER : ST_LINE0;
            end

            ST_LINE0, ST_LINE1, ST_LINE2: begin
               if (in_exline) begin
                  in_exline <= 1'b0;
                  state     <= ST_HEADER;
               end else if (i_tlast && has_exline) begin
                  in_exline <= 1'b1;
                  state     <= next_line;
               end else if (i_tlast) begin
                  state <= ST_HEADER;
               end else begin
                  state <= next_line;
               end
            end

            ST_LINE3: begin
               if (in_exline) begin
                  in_exline <= 1'b0;
                  state     <= ST_HEADER;
               end else begin
                  state <= ST_LINE0;
               end
            end

            default: begin
               state <= ST_HEADER;
            end
         endcase
      end
   end

   assign o_state = state;

endmodule

//--- verilog/sample_repacker.sv
/* Data path of the unpacker. Keeps the previous input line and builds each
   output line from it and the current one. */

`timescale 1ns/100ps

module sample_repacker
   import unpack_pkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  unpack_state_t    i_state,
   input  logic             i_hold_en,
   input  logic [63:0]      i_tdata,
   input  logic [15:0]      i_out_len,
   input  logic             i_sid_en,
   input  logic [SID_W-1:0] i_new_dest,
   output logic [63:0]      o_tdata
);

   logic [63:0] hold_tdata;
   logic [47:0] iq12;        // Four 12-bit values, first one in the top bits.
   logic [31:0] hdr_ids;

   // A 12-bit value goes to the top of a 16-bit lane.
   function automatic logic [15:0] expand_12(input logic [11:0] v);
      return {v, 4'h0};
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_tdata <= '0;
      end else if (i_hold_en) begin
         hold_tdata <= i_tdata;
      end
   end

   // ########################################################################
   // Three input lines spread over four output lines
   // ########################################################################

   always_comb begin
      case (i_state)
         ST_LINE0: iq12 = i_tdata[63:16];
         ST_LINE1: iq12 = {hold_tdata[15:0], i_tdata[63:32]};
         ST_LINE2: iq12 = {hold_tdata[31:0], i_tdata[63:48]};
         ST_LINE3: iq12 = hold_tdata[47:0];
         default:  iq12 = '0;
      endcase
   end

   // Old destination moves up into the source half when the override is on.
   assign hdr_ids = i_sid_en ? {i_tdata[SID_W-1:0], i_new_dest} : i_tdata[LEN_LSB-1:0];

   always_comb begin
      case (i_state)
         ST_HEADER: o_tdata = {i_tdata[63:LEN_MSB+1], i_out_len, hdr_ids};
         ST_TIME:   o_tdata = i_tdata;
         default: begin
            o_tdata = {expand_12(iq12[47:36]),
                       expand_12(iq12[35:24]),
                       expand_12(iq12[23:12]),
                       expand_12(iq12[11:0])};
         end
      endcase
   end

endmodule

//--- verilog/chdr_12sc_to_16sc.sv
/* CHDR unpacker from 12-bit to 16-bit complex samples, with header length
   rewrite and an optional destination stream ID override. */

`timescale 1ns/100ps

module chdr_12sc_to_16sc
   import unpack_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   // Settings bus.
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  logic [31:0] i_set_data,
   // Input stream, 12-bit samples.
   input  logic [63:0] i_tdata,
   input  logic        i_tlast,
   input  logic        i_tvalid,
   output logic        o_tready_in,
   // Output stream, 16-bit samples.
   output logic [63:0] o_tdata,
   output logic        o_tlast,
   output logic        o_tvalid,
   input  logic        i_tready_out
);

   unpack_state_t    state;
   logic             hold_en;
   logic             sid_en;
   logic [SID_W-1:0] new_dest;
   logic [15:0]      out_len;
   logic             has_exline;

   sid_setting_reg u_sid_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_sid_en   (sid_en),
      .o_new_dest (new_dest)
   );

   pkt_length_calc u_len_calc (
      .i_hdr        (i_tdata),   // Only sampled by the FSM in the header phase.
      .o_out_len    (out_len),
      .o_has_exline (has_exline)
   );

   unpack_ctrl_fsm u_ctrl (
      .clk          (clk),
      .reset        (reset),
      .i_tlast      (i_tlast),
      .i_tvalid     (i_tvalid),
      .i_tready     (i_tready_out),
      .i_has_time   (i_tdata[HDR_HAS_TIME_BIT]),
      .i_has_exline (has_exline),
      .o_state      (state),
      .o_in_tready  (o_tready_in),
      .o_out_tvalid (o_tvalid),
      .o_out_tlast  (o_tlast),
      .o_hold_en    (hold_en)
   );

   sample_repacker u_repack (
      .clk        (clk),
      .reset      (reset),
      .i_state    (state),
      .i_hold_en  (hold_en),
      .i_tdata    (i_tdata),
      .i_out_len  (out_len),
      .i_sid_en   (sid_en),
      .i_new_dest (new_dest),
      .o_tdata    (o_tdata)
   );

endmodule

//--- test/unpack_checker.sv
/* Output stream checker for the CHDR unpacker. Builds each expected packet
   from the queued input packet and compares every output beat with it. */

`timescale 1ns/100ps

module unpack_checker
   import unpack_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] i_tdata,
   input  logic        i_tlast,
   input  logic        i_tvalid,
   input  logic        i_tready,
   output int          o_pkts_done,
   output int          o_data_errs,
   output int          o_frame_errs
);

   logic [144:0] desc_q[$];    // {sid_en, new_dest, time word, header}.
   logic [23:0]  samp_q[$];    // One {I, Q} sample per entry.
   logic [63:0]  exp_line[$];
   logic [63:0]  exp_mask[$];  // Padding lanes of an odd last sample are not compared.
   logic         in_pkt;

   // ########################################################################
   // Reference model
   // ########################################################################

   function automatic void build_expected(input logic [144:0] desc);
      logic [63:0] hdr;
      logic [63:0] line;
      logic [63:0] mask;
      logic [31:0] lane;
      logic [23:0] s;
      logic [15:0] hdr_bytes;
      logic [15:0] out_len;
      int          n_samp;
      int          j;
      hdr       = desc[63:0];
      hdr_bytes = HDR_BYTES + (hdr[HDR_HAS_TIME_BIT] ? TIME_BYTES : 16'd0);
      n_samp    = int'(hdr[LEN_MSB:LEN_LSB] - hdr_bytes) / 3;
      out_len   = hdr_bytes + 16'(4 * n_samp);  // Each 3-byte sample becomes 4 bytes.
      line      = {hdr[63:48], out_len, hdr[31:0]};
      if (desc[144]) begin
         line[31:0] = {hdr[15:0], desc[143:128]};  // Old destination moves to the source half.
      end
      exp_line.delete();
      exp_mask.delete();
      exp_line.push_back(line);
      exp_mask.push_back('1);
      if (hdr[HDR_HAS_TIME_BIT]) begin
         exp_line.push_back(desc[127:64]);
         exp_mask.push_back('1);
      end
      line = '0;
      mask = '0;
      for (j = 0; j < n_samp; j++) begin
         s    = samp_q.pop_front();
         lane = {s[23:12], 4'h0, s[11:0], 4'h0};
         if (j % 2 == 0) begin
            line = {lane, 32'h0};
            mask = {32'hffff_ffff, 32'h0};
         end else begin
            line[31:0] = lane;
            mask       = '1;
         end
         if ((j % 2 == 1) || (j == n_samp - 1)) begin
            exp_line.push_back(line);
            exp_mask.push_back(mask);
         end
      end
   endfunction

   task automatic check_beat();
      logic [63:0] want;
      logic [63:0] mask;
      if (!in_pkt) begin
         if (desc_q.size() == 0) begin
            $display("Output beat at %0t arrived with no input packet outstanding", $time);
            o_frame_errs++;
         end else begin
            build_expected(desc_q.pop_front());
         end
         in_pkt = 1'b1;
      end
      if (exp_line.size() == 0) begin
         $display("** Error at %0t: packet %0d has a beat past its end", $time, o_pkts_done);
         o_frame_errs++;
      end else begin
         want = exp_line.pop_front();
         mask = exp_mask.pop_front();
         if ((i_tdata & mask) !== (want & mask)) begin
            $display("** Error at %0t: packet %0d data %h, expected %h",
                     $time, o_pkts_done, i_tdata, want);
            o_data_errs++;
         end
         if (i_tlast !== (exp_line.size() == 0)) begin
            $display("** Error at %0t: packet %0d tlast %b, expected %b",
                     $time, o_pkts_done, i_tlast, exp_line.size() == 0);
            o_frame_errs++;
         end
      end
      if (i_tlast) begin
         in_pkt = 1'b0;
         o_pkts_done++;
         exp_line.delete();
         exp_mask.delete();
      end
   endtask

   initial begin
      o_pkts_done  = 0;
      o_data_errs  = 0;
      o_frame_errs = 0;
      in_pkt       = 1'b0;
   end

   always @(posedge clk) begin
      if (reset) begin
         in_pkt = 1'b0;
      end else if (i_tvalid && i_tready) begin
         check_beat();
      end
   end

endmodule

//--- test/tb_chdr_unpack.sv
/* Testbench for the CHDR 12-bit to 16-bit unpacker. Sends random packets
   with and without stream gaps, and writes the destination override. */

`timescale 1ns/100ps

module tb_chdr_unpack
   import unpack_pkg::*;
();

   localparam int BEAT_TIMEOUT = 100;
   localparam int IDLE_TIMEOUT = 1000;

   logic        clk;
   logic        reset;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic [63:0] in_tdata;
   logic        in_tlast;
   logic        in_tvalid;
   logic        in_tready;
   logic [63:0] out_tdata;
   logic        out_tlast;
   logic        out_tvalid;
   logic        out_tready;
   logic        gaps_on;        // Random idle cycles on both streams.
   logic        model_sid_en;
   logic [15:0] model_dest;
   int          pkts_sent;
   int          pkts_done;
   int          data_errs;
   int          frame_errs;

   chdr_12sc_to_16sc dut0 (
      .clk          (clk),
      .reset        (reset),
      .i_set_stb    (set_stb),
      .i_set_addr   (set_addr),
      .i_set_data   (set_data),
      .i_tdata      (in_tdata),
      .i_tlast      (in_tlast),
      .i_tvalid     (in_tvalid),
      .o_tready_in  (in_tready),
      .o_tdata      (out_tdata),
      .o_tlast      (out_tlast),
      .o_tvalid     (out_tvalid),
      .i_tready_out (out_tready)
   );

   unpack_checker chk0 (
      .clk          (clk),
      .reset        (reset),
      .i_tdata      (out_tdata),
      .i_tlast      (out_tlast),
      .i_tvalid     (out_tvalid),
      .i_tready     (out_tready),
      .o_pkts_done  (pkts_done),
      .o_data_errs  (data_errs),
      .o_frame_errs (frame_errs)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      out_tready = 1'b0;
      forever begin
         @(negedge clk);
         out_tready = !reset && (!gaps_on || ($urandom_range(3) != 0));
      end
   end

   task automatic print_counts();
      $display("Checked %0d of %0d packets: %0d data errors, %0d framing errors",
               pkts_done, pkts_sent, data_errs, frame_errs);
   endtask

   task automatic abort_run(input string reason);
      $display("Timeout at %0t: %s", $time, reason);
      print_counts();
      $display("Simulation failed");
      $finish;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge clk);
      set_stb = 1'b0;
      if (addr == SID_REG_ADDR) begin
         model_sid_en = data[16];
         model_dest   = data[15:0];
      end
   endtask

   task automatic send_beat(input logic [63:0] data, input logic last);
      int   tries;
      logic took;
      while (gaps_on && ($urandom_range(3) == 0)) begin
         in_tvalid = 1'b0;
         @(negedge clk);
      end
      in_tdata  = data;
      in_tlast  = last;
      in_tvalid = 1'b1;
      tries     = 0;
      took      = 1'b0;
      while (!took) begin
         @(posedge clk);
         took = in_tready;  // Sampled before the DUT state moves.
         tries++;
         if (!took && (tries > BEAT_TIMEOUT)) begin
            abort_run("input beat was never accepted");
         end
      end
      @(negedge clk);
      in_tvalid = 1'b0;
   endtask

   task automatic send_packet(input int n_samp, input logic has_time);
      logic [575:0] stream;     // Room for 24 samples, first one on top.
      logic [575:0] shifted;
      logic [63:0]  hdr;
      logic [63:0]  tw;
      logic [23:0]  s;
      int           n_lines;
      int           i;
      hdr                   = {$urandom, $urandom};
      tw                    = {$urandom, $urandom};
      hdr[HDR_HAS_TIME_BIT] = has_time;
      hdr[LEN_MSB:LEN_LSB]  = 16'(8 + (has_time ? 8 : 0) + 3 * n_samp);
      stream                = '0;
      for (i = 0; i < n_samp; i++) begin
         s      = 24'($urandom);
         stream = {stream[551:0], s};
         chk0.samp_q.push_back(s);
      end
      n_lines = (24 * n_samp + 63) / 64;
      stream  = stream << (64 * n_lines - 24 * n_samp);  // Zero pad the last line.
      chk0.desc_q.push_back({model_sid_en, model_dest, tw, hdr});
      pkts_sent++;
      send_beat(hdr, 1'b0);
      if (has_time) begin
         send_beat(tw, 1'b0);
      end
      for (i = 0; i < n_lines; i++) begin
         shifted = stream >> (64 * (n_lines - 1 - i));
         send_beat(shifted[63:0], i == n_lines - 1);
      end
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (pkts_done != pkts_sent) begin
         @(negedge clk);
         cycles++;
         if (cycles > IDLE_TIMEOUT) begin
            abort_run("output packets still outstanding");
         end
      end
   endtask

   // ########################################################################
   // Test sequence
   // ########################################################################

   initial begin
      int seed;
      int p;
      seed         = $urandom(32'hb0d2);
      reset        = 1'b1;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      in_tdata     = '0;
      in_tlast     = 1'b0;
      in_tvalid    = 1'b0;
      gaps_on      = 1'b0;
      model_sid_en = 1'b0;
      model_dest   = '0;
      pkts_sent    = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Every sample count modulo eight, with and without a time word.
      for (p = 1; p <= 8; p++) begin
         send_packet(3 * p, 1'b0);
         send_packet(3 * p, 1'b1);
      end
      wait_idle();

      write_setting(SID_REG_ADDR, {15'd0, 1'b1, 16'($urandom)});
      write_setting(SID_REG_ADDR + 8'd1, 32'h0001_ffff);  // Wrong address, ignored.
      for (p = 0; p < 12; p++) begin
         send_packet(3 * $urandom_range(1, 8), 1'($urandom_range(1)));
      end
      wait_idle();

      @(posedge clk);
      gaps_on = 1'b1;
      @(negedge clk);
      for (p = 0; p < 24; p++) begin
         send_packet(3 * $urandom_range(1, 8), 1'($urandom_range(1)));
      end
      wait_idle();

      write_setting(SID_REG_ADDR, {15'd0, 1'b0, 16'($urandom)});
      for (p = 0; p < 12; p++) begin
         send_packet(3 * $urandom_range(1, 8), 1'($urandom_range(1)));
      end
      wait_idle();

      print_counts();
      if ((data_errs == 0) && (frame_errs == 0)) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- compile.f
verilog/unpack_pkg.sv
verilog/sid_setting_reg.sv
verilog/pkt_length_calc.sv
verilog/unpack_ctrl_fsm.sv
verilog/sample_repacker.sv
verilog/chdr_12sc_to_16sc.sv
test/unpack_checker.sv
test/tb_chdr_unpack.sv

//--- Makefile
TOP := tb_chdr_unpack

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) \
		-f compile.f -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
